// File: src/exec_pkg.sv
// lane count, warp count, opcode encodings and shared datapath typedefs for the execute stage
`default_nettype none

package exec_pkg;

    // machine shape
    localparam int XLEN       = 32;
    localparam int THREAD_CNT = 4;
    localparam int NUM_WARPS  = 4;
    localparam int NW_BITS    = $clog2(NUM_WARPS);
    localparam int REG_BITS   = 5;
    localparam int OP_BITS    = 4;

    // one lane value
    typedef logic [XLEN-1:0] word_t;

    // all lanes packed side by side with lane 0 in the low word
    typedef logic [THREAD_CNT*XLEN-1:0] lanes_t;

    // one active bit per lane
    typedef logic [THREAD_CNT-1:0] tmask_t;

    typedef logic [NW_BITS-1:0] wid_t;
    typedef logic [REG_BITS-1:0] reg_t;
    typedef logic [OP_BITS-1:0] op_t;

    // integer ALU operations, evaluated in every lane
    localparam op_t OP_ADD    = 4'd0;
    localparam op_t OP_SUB    = 4'd1;
    localparam op_t OP_AND    = 4'd2;
    localparam op_t OP_OR     = 4'd3;
    localparam op_t OP_XOR    = 4'd4;

    // signed compare whose result is 0 or 1
    localparam op_t OP_SLT    = 4'd5;

    // shift amount is the low five bits of rs2
    localparam op_t OP_SLL    = 4'd6;
    localparam op_t OP_SRL    = 4'd7;

    // conditional branches resolve on lane 0 only
    localparam op_t OP_BEQ    = 4'd8;
    localparam op_t OP_BNE    = 4'd9;
    localparam op_t OP_BLT    = 4'd10;

    // jal writes pc+4 into every lane and always redirects
    localparam op_t OP_JAL    = 4'd11;

    // warp control and the simulation stop request
    localparam op_t OP_TMC    = 4'd12;
    localparam op_t OP_EBREAK = 4'd13;

    // values above this one are not decoded
    localparam op_t OP_LAST   = OP_EBREAK;

endpackage

`default_nettype wire

// File: src/operand_stage.sv
// first pipeline register with dispatch field capture and opcode class decode
`default_nettype none

module operand_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             dispatch_valid,
    input  exec_pkg::wid_t   dispatch_wid,
    input  exec_pkg::tmask_t dispatch_tmask,
    input  exec_pkg::word_t  dispatch_pc,
    input  exec_pkg::op_t    dispatch_op,
    input  exec_pkg::lanes_t dispatch_rs1,
    input  exec_pkg::lanes_t dispatch_rs2,
    input  exec_pkg::word_t  dispatch_imm,
    input  exec_pkg::reg_t   dispatch_rd,
    output logic             s1_valid,
    output exec_pkg::wid_t   s1_wid,
    output exec_pkg::tmask_t s1_tmask,
    output exec_pkg::word_t  s1_pc,
    output exec_pkg::op_t    s1_op,
    output exec_pkg::lanes_t s1_rs1,
    output exec_pkg::lanes_t s1_rs2,
    output exec_pkg::word_t  s1_imm,
    output exec_pkg::reg_t   s1_rd,
    output logic             s1_is_br,
    output logic             s1_is_ctl
);
    import exec_pkg::*;

    logic is_br;
    logic is_ctl;

    // jal is grouped with the branches since it also redirects the warp
    assign is_br  = (dispatch_op == OP_BEQ) || (dispatch_op == OP_BNE)
                 || (dispatch_op == OP_BLT) || (dispatch_op == OP_JAL);
    assign is_ctl = (dispatch_op == OP_TMC) || (dispatch_op == OP_EBREAK);

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= dispatch_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_wid    <= dispatch_wid;
        s1_tmask  <= dispatch_tmask;
        s1_pc     <= dispatch_pc;
        s1_op     <= dispatch_op;
        s1_rs1    <= dispatch_rs1;
        s1_rs2    <= dispatch_rs2;
        s1_imm    <= dispatch_imm;
        s1_rd     <= dispatch_rd;
        s1_is_br  <= is_br;
        s1_is_ctl <= is_ctl;
    end

    // the issue side must never hand over an opcode that no stage decodes
    a_legal_op: assert property (@(posedge clk) disable iff (rst)
        dispatch_valid |-> (dispatch_op <= OP_LAST))
        else $error("illegal opcode %0d dispatched", dispatch_op);

endmodule

`default_nettype wire

// File: src/alu_stage.sv
// second pipeline stage with per-lane integer results, lane 0 branch compare and target
`default_nettype none

module alu_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             s1_valid,
    input  exec_pkg::wid_t   s1_wid,
    input  exec_pkg::tmask_t s1_tmask,
    input  exec_pkg::word_t  s1_pc,
    input  exec_pkg::op_t    s1_op,
    input  exec_pkg::lanes_t s1_rs1,
    input  exec_pkg::lanes_t s1_rs2,
    input  exec_pkg::word_t  s1_imm,
    input  exec_pkg::reg_t   s1_rd,
    input  logic             s1_is_br,
    input  logic             s1_is_ctl,
    output logic             s2_valid,
    output exec_pkg::wid_t   s2_wid,
    output exec_pkg::tmask_t s2_tmask,
    output exec_pkg::word_t  s2_pc,
    output exec_pkg::op_t    s2_op,
    output exec_pkg::reg_t   s2_rd,
    output exec_pkg::lanes_t s2_result,
    output logic             s2_cmp,
    output exec_pkg::word_t  s2_target,
    output exec_pkg::tmask_t s2_tmc_mask,
    output logic             s2_is_br,
    output logic             s2_is_ctl
);
    import exec_pkg::*;

    lanes_t lane_result;
    word_t  rs1_l0;
    word_t  rs2_l0;
    logic   cmp;

    for (genvar i = 0; i < THREAD_CNT; i++) begin : g_lane
        word_t a;
        word_t b;
        word_t r;

        assign a = s1_rs1[i*XLEN +: XLEN];
        assign b = s1_rs2[i*XLEN +: XLEN];

        always_comb begin
            case (s1_op)
                OP_ADD:  r = a + b;
                OP_SUB:  r = a - b;
                OP_AND:  r = a & b;
                OP_OR:   r = a | b;
                OP_XOR:  r = a ^ b;
                OP_SLT:  r = {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
                OP_SLL:  r = a << b[4:0];
                OP_SRL:  r = a >> b[4:0];
                // the link address is the same value for every lane
                OP_JAL:  r = s1_pc + word_t'(4);
                default: r = '0;
            endcase
        end

        assign lane_result[i*XLEN +: XLEN] = r;
    end

    // branch decisions only ever look at lane 0
    assign rs1_l0 = s1_rs1[XLEN-1:0];
    assign rs2_l0 = s1_rs2[XLEN-1:0];

    always_comb begin
        case (s1_op)
            OP_BEQ:  cmp = (rs1_l0 == rs2_l0);
            OP_BNE:  cmp = (rs1_l0 != rs2_l0);
            OP_BLT:  cmp = ($signed(rs1_l0) < $signed(rs2_l0));
            default: cmp = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s2_wid      <= s1_wid;
        s2_tmask    <= s1_tmask;
        s2_pc       <= s1_pc;
        s2_op       <= s1_op;
        s2_rd       <= s1_rd;
        s2_result   <= lane_result;
        s2_cmp      <= cmp;
        s2_target   <= s1_pc + s1_imm;
        s2_tmc_mask <= rs1_l0[THREAD_CNT-1:0];
        s2_is_br    <= s1_is_br;
        s2_is_ctl   <= s1_is_ctl;
    end

endmodule

`default_nettype wire

// File: src/branch_resolve.sv
// third stage branch, tmc, flush and ebreak resolution with registered pulses
`default_nettype none

module branch_resolve (
    input  logic             clk,
    input  logic             rst,
    input  logic             s2_valid,
    input  exec_pkg::wid_t   s2_wid,
    input  exec_pkg::op_t    s2_op,
    input  logic             s2_cmp,
    input  exec_pkg::word_t  s2_target,
    input  exec_pkg::tmask_t s2_tmc_mask,
    input  logic             s2_is_br,
    input  logic             s2_is_ctl,
    output logic             branch_valid,
    output exec_pkg::wid_t   branch_wid,
    output logic             branch_taken,
    output exec_pkg::word_t  branch_target,
    output logic             tmc_valid,
    output exec_pkg::wid_t   tmc_wid,
    output exec_pkg::tmask_t tmc_mask,
    output logic             flush,
    output logic             sim_ebreak
);
    import exec_pkg::*;

    logic br_fire;
    logic taken;
    logic tmc_fire;
    logic tmc_zero;
    logic ebreak_fire;

    assign br_fire  = s2_valid && s2_is_br;
    // jal carries no compare and always redirects
    assign taken    = (s2_op == OP_JAL) || s2_cmp;

    assign tmc_fire = s2_valid && s2_is_ctl && (s2_op == OP_TMC);
    assign tmc_zero = (s2_tmc_mask == '0);

    // only warp 0 may stop the simulation
    assign ebreak_fire = s2_valid && s2_is_ctl && (s2_op == OP_EBREAK)
                      && (s2_wid == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            branch_valid <= 1'b0;
            tmc_valid    <= 1'b0;
            flush        <= 1'b0;
            sim_ebreak   <= 1'b0;
        end else begin
            branch_valid <= br_fire;
            tmc_valid    <= tmc_fire;
            // a warp that masks off all of its threads drops out just as a redirect does
            flush        <= (br_fire && taken) || (tmc_fire && tmc_zero);
            sim_ebreak   <= ebreak_fire;
        end
    end

    always_ff @(posedge clk) begin
        branch_wid    <= s2_wid;
        branch_taken  <= taken;
        branch_target <= s2_target;
        tmc_wid       <= s2_wid;
        tmc_mask      <= s2_tmc_mask;
    end

    // operand_stage decodes the two classes apart, so one instruction raises only one of them
    a_br_tmc_excl: assert property (@(posedge clk) disable iff (rst)
        !(branch_valid && tmc_valid))
        else $error("branch_valid and tmc_valid raised together");

endmodule

`default_nettype wire

// File: src/commit_stage.sv
// third stage writeback register with commit pulse generation
`default_nettype none

module commit_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             s2_valid,
    input  exec_pkg::wid_t   s2_wid,
    input  exec_pkg::tmask_t s2_tmask,
    input  exec_pkg::reg_t   s2_rd,
    input  exec_pkg::lanes_t s2_result,
    input  logic             s2_is_br,
    input  exec_pkg::op_t    s2_op,
    output logic             commit_valid,
    output exec_pkg::wid_t   commit_wid,
    output exec_pkg::tmask_t commit_tmask,
    output exec_pkg::reg_t   commit_rd,
    output logic             commit_wb,
    output exec_pkg::lanes_t commit_data
);
    import exec_pkg::*;

    logic wb;

    // among the branch class only jal leaves a link value, and tmc and ebreak write nothing
    assign wb = s2_is_br ? (s2_op == OP_JAL) : (s2_op <= OP_SRL);

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        commit_wid   <= s2_wid;
        commit_tmask <= s2_tmask;
        commit_rd    <= s2_rd;
        commit_wb    <= wb;
        commit_data  <= s2_result;
    end

    // a warp with no active thread is never issued with a register write
    a_wb_mask: assert property (@(posedge clk) disable iff (rst)
        (commit_valid && commit_wb) |-> (commit_tmask != '0))
        else $error("writeback committed with an empty thread mask");

endmodule

`default_nettype wire

// File: src/execute_top.sv
// top level that chains the operand, alu, branch resolve and commit stages
`default_nettype none

module execute_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             dispatch_valid,
    input  exec_pkg::wid_t   dispatch_wid,
    input  exec_pkg::tmask_t dispatch_tmask,
    input  exec_pkg::word_t  dispatch_pc,
    input  exec_pkg::op_t    dispatch_op,
    input  exec_pkg::lanes_t dispatch_rs1,
    input  exec_pkg::lanes_t dispatch_rs2,
    input  exec_pkg::word_t  dispatch_imm,
    input  exec_pkg::reg_t   dispatch_rd,
    output logic             commit_valid,
    output exec_pkg::wid_t   commit_wid,
    output exec_pkg::tmask_t commit_tmask,
    output exec_pkg::reg_t   commit_rd,
    output logic             commit_wb,
    output exec_pkg::lanes_t commit_data,
    output logic             branch_valid,
    output exec_pkg::wid_t   branch_wid,
    output logic             branch_taken,
    output exec_pkg::word_t  branch_target,
    output logic             tmc_valid,
    output exec_pkg::wid_t   tmc_wid,
    output exec_pkg::tmask_t tmc_mask,
    output logic             flush,
    output logic             sim_ebreak
);
    import exec_pkg::*;

    // stage 1 fields
    logic   s1_valid;
    wid_t   s1_wid;
    tmask_t s1_tmask;
    word_t  s1_pc;
    op_t    s1_op;
    lanes_t s1_rs1;
    lanes_t s1_rs2;
    word_t  s1_imm;
    reg_t   s1_rd;
    logic   s1_is_br;
    logic   s1_is_ctl;

    // stage 2 fields shared by branch resolve and commit
    logic   s2_valid;
    wid_t   s2_wid;
    tmask_t s2_tmask;
    op_t    s2_op;
    reg_t   s2_rd;
    lanes_t s2_result;
    logic   s2_cmp;
    word_t  s2_target;
    tmask_t s2_tmc_mask;
    logic   s2_is_br;
    logic   s2_is_ctl;

    operand_stage u_operand_stage (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_wid   (dispatch_wid),
        .dispatch_tmask (dispatch_tmask),
        .dispatch_pc    (dispatch_pc),
        .dispatch_op    (dispatch_op),
        .dispatch_rs1   (dispatch_rs1),
        .dispatch_rs2   (dispatch_rs2),
        .dispatch_imm   (dispatch_imm),
        .dispatch_rd    (dispatch_rd),
        .s1_valid       (s1_valid),
        .s1_wid         (s1_wid),
        .s1_tmask       (s1_tmask),
        .s1_pc          (s1_pc),
        .s1_op          (s1_op),
        .s1_rs1         (s1_rs1),
        .s1_rs2         (s1_rs2),
        .s1_imm         (s1_imm),
        .s1_rd          (s1_rd),
        .s1_is_br       (s1_is_br),
        .s1_is_ctl      (s1_is_ctl)
    );

    alu_stage u_alu_stage (
        .clk         (clk),
        .rst         (rst),
        .s1_valid    (s1_valid),
        .s1_wid      (s1_wid),
        .s1_tmask    (s1_tmask),
        .s1_pc       (s1_pc),
        .s1_op       (s1_op),
        .s1_rs1      (s1_rs1),
        .s1_rs2      (s1_rs2),
        .s1_imm      (s1_imm),
        .s1_rd       (s1_rd),
        .s1_is_br    (s1_is_br),
        .s1_is_ctl   (s1_is_ctl),
        .s2_valid    (s2_valid),
        .s2_wid      (s2_wid),
        .s2_tmask    (s2_tmask),
        .s2_pc       (),
        .s2_op       (s2_op),
        .s2_rd       (s2_rd),
        .s2_result   (s2_result),
        .s2_cmp      (s2_cmp),
        .s2_target   (s2_target),
        .s2_tmc_mask (s2_tmc_mask),
        .s2_is_br    (s2_is_br),
        .s2_is_ctl   (s2_is_ctl)
    );

    branch_resolve u_branch_resolve (
        .clk           (clk),
        .rst           (rst),
        .s2_valid      (s2_valid),
        .s2_wid        (s2_wid),
        .s2_op         (s2_op),
        .s2_cmp        (s2_cmp),
        .s2_target     (s2_target),
        .s2_tmc_mask   (s2_tmc_mask),
        .s2_is_br      (s2_is_br),
        .s2_is_ctl     (s2_is_ctl),
        .branch_valid  (branch_valid),
        .branch_wid    (branch_wid),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .tmc_valid     (tmc_valid),
        .tmc_wid       (tmc_wid),
        .tmc_mask      (tmc_mask),
        .flush         (flush),
        .sim_ebreak    (sim_ebreak)
    );

    commit_stage u_commit_stage (
        .clk          (clk),
        .rst          (rst),
        .s2_valid     (s2_valid),
        .s2_wid       (s2_wid),
        .s2_tmask     (s2_tmask),
        .s2_rd        (s2_rd),
        .s2_result    (s2_result),
        .s2_is_br     (s2_is_br),
        .s2_op        (s2_op),
        .commit_valid (commit_valid),
        .commit_wid   (commit_wid),
        .commit_tmask (commit_tmask),
        .commit_rd    (commit_rd),
        .commit_wb    (commit_wb),
        .commit_data  (commit_data)
    );

endmodule

`default_nettype wire

// File: tb/tb_execute.sv
// testbench for execute_top with LFSR stimulus, a reference model queue and output assertions
`default_nettype none

module tb_execute;
    import exec_pkg::*;

    // one expected output set that falls due at the cycle in due
    typedef struct packed {
        logic [31:0] due;
        wid_t        wid;
        tmask_t      tmask;
        reg_t        rd;
        logic        wb;
        lanes_t      data;
        logic        br;
        logic        taken;
        word_t       target;
        logic        tmc;
        tmask_t      tmc_mask;
        logic        flush;
        logic        ebreak;
    } exp_t;

    logic clk = 1'b0;
    logic rst;
    logic dispatch_valid;
    wid_t dispatch_wid;
    tmask_t dispatch_tmask;
    word_t dispatch_pc;
    op_t dispatch_op;
    lanes_t dispatch_rs1;
    lanes_t dispatch_rs2;
    word_t dispatch_imm;
    reg_t dispatch_rd;
    logic commit_valid;
    wid_t commit_wid;
    tmask_t commit_tmask;
    reg_t commit_rd;
    logic commit_wb;
    lanes_t commit_data;
    logic branch_valid;
    wid_t branch_wid;
    logic branch_taken;
    word_t branch_target;
    logic tmc_valid;
    wid_t tmc_wid;
    tmask_t tmc_mask;
    logic flush;
    logic sim_ebreak;

    logic [31:0] cyc = 32'd0;
    logic [31:0] lfsr;
    exp_t exp_q[$];
    exp_t cur;
    logic cur_valid;
    int value_errs = 0;
    int proto_errs = 0;

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 32'd1;
    end

    execute_top u_execute_top (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_wid   (dispatch_wid),
        .dispatch_tmask (dispatch_tmask),
        .dispatch_pc    (dispatch_pc),
        .dispatch_op    (dispatch_op),
        .dispatch_rs1   (dispatch_rs1),
        .dispatch_rs2   (dispatch_rs2),
        .dispatch_imm   (dispatch_imm),
        .dispatch_rd    (dispatch_rd),
        .commit_valid   (commit_valid),
        .commit_wid     (commit_wid),
        .commit_tmask   (commit_tmask),
        .commit_rd      (commit_rd),
        .commit_wb      (commit_wb),
        .commit_data    (commit_data),
        .branch_valid   (branch_valid),
        .branch_wid     (branch_wid),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target),
        .tmc_valid      (tmc_valid),
        .tmc_wid        (tmc_wid),
        .tmc_mask       (tmc_mask),
        .flush          (flush),
        .sim_ebreak     (sim_ebreak)
    );

    // Galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic word_t calc_lane(input op_t op, input word_t a, input word_t b,
                                        input word_t pc);
        case (op)
            OP_ADD: return a + b;
            OP_SUB: return a - b;
            OP_AND: return a & b;
            OP_OR:  return a | b;
            OP_XOR: return a ^ b;
            OP_SLT: return {31'd0, ($signed(a) < $signed(b))};
            OP_SLL: return a << b[4:0];
            OP_SRL: return a >> b[4:0];
            OP_JAL: return pc + 32'd4;
            default: return '0;
        endcase
    endfunction

    function automatic logic branch_cmp(input op_t op, input word_t a, input word_t b);
        case (op)
            OP_BEQ: return a == b;
            OP_BNE: return a != b;
            OP_BLT: return $signed(a) < $signed(b);
            default: return 1'b0;
        endcase
    endfunction

    // all ones in every word whose lane is active
    function automatic lanes_t lane_enable(input tmask_t m);
        lanes_t r;
        for (int i = 0; i < THREAD_CNT; i++) begin
            r[i*XLEN +: XLEN] = {XLEN{m[i]}};
        end
        return r;
    endfunction

    task automatic report_value(input string name, input logic [127:0] exp_v,
                                input logic [127:0] got_v);
        value_errs++;
        $display("error t=%0t %s expected %0h actual %0h", $time, name, exp_v, got_v);
    endtask

    task automatic report_pulse(input string name, input logic got);
        proto_errs++;
        if (got) begin
            $display("unexpected %s pulse at time %0t with no matching instruction", name, $time);
        end else begin
            $display("missing %s pulse at time %0t", name, $time);
        end
    endtask

    task automatic send_instr(input op_t op, input wid_t wid, input tmask_t tmask,
                              input word_t pc, input lanes_t rs1, input lanes_t rs2,
                              input word_t imm, input reg_t rd);
        exp_t e;
        @(posedge clk);
        dispatch_valid <= 1'b1;
        dispatch_op <= op;
        dispatch_wid <= wid;
        dispatch_tmask <= tmask;
        dispatch_pc <= pc;
        dispatch_rs1 <= rs1;
        dispatch_rs2 <= rs2;
        dispatch_imm <= imm;
        dispatch_rd <= rd;
        // outputs are registered three edges after this one
        e.due = cyc + 32'd3;
        e.wid = wid;
        e.tmask = tmask;
        e.rd = rd;
        e.wb = (op <= OP_SRL) || (op == OP_JAL);
        for (int i = 0; i < THREAD_CNT; i++) begin
            e.data[i*XLEN +: XLEN] = calc_lane(op, rs1[i*XLEN +: XLEN], rs2[i*XLEN +: XLEN], pc);
        end
        e.br = (op == OP_BEQ) || (op == OP_BNE) || (op == OP_BLT) || (op == OP_JAL);
        e.taken = (op == OP_JAL) || branch_cmp(op, rs1[XLEN-1:0], rs2[XLEN-1:0]);
        e.target = pc + imm;
        e.tmc = (op == OP_TMC);
        e.tmc_mask = rs1[THREAD_CNT-1:0];
        e.flush = (e.br && e.taken) || (e.tmc && (e.tmc_mask == '0));
        e.ebreak = (op == OP_EBREAK) && (wid == '0);
        exp_q.push_back(e);
    endtask

    task automatic send_random();
        logic [31:0] v;
        op_t op;
        wid_t wid;
        tmask_t tm;
        word_t pc;
        lanes_t rs1;
        lanes_t rs2;
        word_t imm;
        reg_t rd;
        draw_bits(4, v);
        op = op_t'(v % 32'd14);
        draw_bits(2, v);
        wid = wid_t'(v);
        // a writeback never goes to a warp with no active lane
        draw_bits(4, v);
        tm = (v[3:0] == 4'd0) ? tmask_t'(1) : tmask_t'(v);
        draw_bits(30, v);
        pc = {v[29:0], 2'b00};
        for (int i = 0; i < THREAD_CNT; i++) begin
            draw_bits(32, v);
            rs1[i*XLEN +: XLEN] = v;
            draw_bits(32, v);
            rs2[i*XLEN +: XLEN] = v;
        end
        // bias lane 0 towards equal operands and a zero tmc mask now and then
        draw_bits(2, v);
        if (v[1:0] == 2'd0) begin
            rs2[XLEN-1:0] = rs1[XLEN-1:0];
        end
        draw_bits(2, v);
        if (v[1:0] == 2'd0) begin
            rs1[THREAD_CNT-1:0] = '0;
        end
        draw_bits(12, v);
        imm = {{20{v[11]}}, v[11:0]};
        draw_bits(5, v);
        rd = reg_t'(v);
        send_instr(op, wid, tm, pc, rs1, rs2, imm, rd);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        dispatch_valid <= 1'b0;
    endtask

    // the model output registers move on the same edge as the DUT outputs
    always @(posedge clk) begin
        if (rst) begin
            cur_valid <= 1'b0;
        end else if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
            cur <= exp_q.pop_front();
            cur_valid <= 1'b1;
        end else begin
            cur_valid <= 1'b0;
        end
    end

    a_commit_pulse: assert property (@(posedge clk) disable iff (rst)
        commit_valid == cur_valid)
        else report_pulse("commit_valid", $sampled(commit_valid));
    a_commit_wid: assert property (@(posedge clk) disable iff (rst)
        (commit_valid && cur_valid) |-> (commit_wid == cur.wid))
        else report_value("commit_wid", 128'($sampled(cur.wid)), 128'($sampled(commit_wid)));
    a_commit_tmask: assert property (@(posedge clk) disable iff (rst)
        (commit_valid && cur_valid) |-> (commit_tmask == cur.tmask))
        else report_value("commit_tmask", 128'($sampled(cur.tmask)),
                          128'($sampled(commit_tmask)));
    a_commit_rd: assert property (@(posedge clk) disable iff (rst)
        (commit_valid && cur_valid) |-> (commit_rd == cur.rd))
        else report_value("commit_rd", 128'($sampled(cur.rd)), 128'($sampled(commit_rd)));
    a_commit_wb: assert property (@(posedge clk) disable iff (rst)
        (commit_valid && cur_valid) |-> (commit_wb == cur.wb))
        else report_value("commit_wb", 128'($sampled(cur.wb)), 128'($sampled(commit_wb)));
    // inactive lanes carry don't-care data
    a_commit_data: assert property (@(posedge clk) disable iff (rst)
        (commit_valid && cur_valid && cur.wb) |->
            ((commit_data & lane_enable(commit_tmask)) == (cur.data & lane_enable(cur.tmask))))
        else report_value("commit_data", $sampled(cur.data) & lane_enable($sampled(cur.tmask)),
                          $sampled(commit_data) & lane_enable($sampled(commit_tmask)));

    a_branch_pulse: assert property (@(posedge clk) disable iff (rst)
        branch_valid == (cur_valid && cur.br))
        else report_pulse("branch_valid", $sampled(branch_valid));
    a_branch_wid: assert property (@(posedge clk) disable iff (rst)
        (branch_valid && cur_valid) |-> (branch_wid == cur.wid))
        else report_value("branch_wid", 128'($sampled(cur.wid)), 128'($sampled(branch_wid)));
    a_branch_taken: assert property (@(posedge clk) disable iff (rst)
        (branch_valid && cur_valid) |-> (branch_taken == cur.taken))
        else report_value("branch_taken", 128'($sampled(cur.taken)),
                          128'($sampled(branch_taken)));
    a_branch_target: assert property (@(posedge clk) disable iff (rst)
        (branch_valid && cur_valid) |-> (branch_target == cur.target))
        else report_value("branch_target", 128'($sampled(cur.target)),
                          128'($sampled(branch_target)));

    a_tmc_pulse: assert property (@(posedge clk) disable iff (rst)
        tmc_valid == (cur_valid && cur.tmc))
        else report_pulse("tmc_valid", $sampled(tmc_valid));
    a_tmc_wid: assert property (@(posedge clk) disable iff (rst)
        (tmc_valid && cur_valid) |-> (tmc_wid == cur.wid))
        else report_value("tmc_wid", 128'($sampled(cur.wid)), 128'($sampled(tmc_wid)));
    a_tmc_mask: assert property (@(posedge clk) disable iff (rst)
        (tmc_valid && cur_valid) |-> (tmc_mask == cur.tmc_mask))
        else report_value("tmc_mask", 128'($sampled(cur.tmc_mask)), 128'($sampled(tmc_mask)));

    a_flush: assert property (@(posedge clk) disable iff (rst)
        flush == (cur_valid && cur.flush))
        else report_value("flush", 128'($sampled(cur_valid && cur.flush)), 128'($sampled(flush)));
    a_ebreak: assert property (@(posedge clk) disable iff (rst)
        sim_ebreak == (cur_valid && cur.ebreak))
        else report_pulse("sim_ebreak", $sampled(sim_ebreak));

    initial begin
        logic [31:0] v;
        int t;
        rst = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_wid = '0;
        dispatch_tmask = '0;
        dispatch_pc = '0;
        dispatch_op = OP_ADD;
        dispatch_rs1 = '0;
        dispatch_rs2 = '0;
        dispatch_imm = '0;
        dispatch_rd = '0;
        lfsr = 32'd91455;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        // a few quiet cycles show that nothing pulses out of reset
        repeat (4) idle_cycle();

        send_instr(OP_TMC, 2'd1, 4'hf, 32'h100, '0, '0, 32'd8, 5'd3);
        send_instr(OP_TMC, 2'd2, 4'h3, 32'h104, lanes_t'(32'h5), '0, 32'd8, 5'd4);
        send_instr(OP_EBREAK, 2'd0, 4'hf, 32'h108, '0, '0, 32'd0, 5'd0);
        send_instr(OP_EBREAK, 2'd3, 4'hf, 32'h10c, '0, '0, 32'd0, 5'd0);
        send_instr(OP_JAL, 2'd0, 4'h9, 32'h200, '0, '0, 32'h40, 5'd1);
        send_instr(OP_BEQ, 2'd1, 4'hf, 32'h300, lanes_t'(32'd7), lanes_t'(32'd7), -32'd16, 5'd0);
        send_instr(OP_BLT, 2'd2, 4'hf, 32'h304, lanes_t'(-32'd1), lanes_t'(32'd1), 32'd12, 5'd0);
        idle_cycle();

        for (int n = 0; n < 400; n++) begin
            draw_bits(3, v);
            if (v == 32'd0) begin
                idle_cycle();
            end
            send_random();
        end
        idle_cycle();

        t = 0;
        while ((exp_q.size() != 0 || cur_valid) && t < 50) begin
            @(posedge clk);
            t++;
        end
        if (exp_q.size() != 0 || cur_valid) begin
            proto_errs++;
            $display("timeout while waiting for %0d instructions to drain", exp_q.size());
        end
        repeat (2) @(posedge clk);

        $display("value errors %0d, protocol errors %0d", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
src/exec_pkg.sv
src/operand_stage.sv
src/alu_stage.sv
src/branch_resolve.sv
src/commit_stage.sv
src/execute_top.sv
tb/tb_execute.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --assert --timing -j 0
TOP       ?= tb_execute
FILELIST  ?= vlog.f
LOG       ?= sim.log

.PHONY: sim clean

# the run passes only if the binary exits cleanly and the log holds no failure
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
